// ==== rv_params.svh ====
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// data and address width
`define RV_XLEN       32

// integer register file
`define RV_REG_COUNT  32
`define RV_REG_IDX_W  5

`define RV_INST_W     32

// sequential fetch addresses
`define RV_PC_RESET   32'h0000_0000
`define RV_PC_STEP    32'd4

`endif

// ==== rv_pkg.sv ====
`default_nettype none

`include "rv_params.svh"

package rv_pkg;

    typedef logic [`RV_XLEN-1:0]      xlen_t;
    typedef logic [`RV_XLEN-1:0]      pc_t;
    typedef logic [`RV_INST_W-1:0]    inst_t;
    typedef logic [`RV_REG_IDX_W-1:0] reg_idx_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        // lui result is op_b as is
        ALU_PASS_B
    } alu_op_t;

    typedef enum logic [1:0] {
        FETCH_REQ,
        FETCH_WAIT_ACK,
        FETCH_WAIT_RELEASE
    } fetch_state_t;

    typedef struct packed {
        logic  valid;
        pc_t   pc;
        inst_t inst;
    } fetched_t;

    typedef struct packed {
        logic     valid;
        pc_t      pc;
        alu_op_t  alu_op;
        reg_idx_t rd_idx;
        logic     rd_en;
        reg_idx_t rs1_idx;
        reg_idx_t rs2_idx;
        logic     use_rs2;
        xlen_t    op_a;
        xlen_t    op_b;
    } decoded_t;

    typedef struct packed {
        logic     valid;
        pc_t      pc;
        reg_idx_t rd_idx;
        logic     rd_en;
        xlen_t    rd_data;
    } commit_t;

endpackage

`default_nettype wire

// ==== inst_fetch.sv ====
`default_nettype none

`include "rv_params.svh"

module inst_fetch (
    input  wire                mem2wb_inst_selfdefine_o,
    input  wire                reset,
    input  wire                fetch_ack_i,
    input  wire rv_pkg::inst_t fetch_data_i,
    output logic               fetch_req_o,
    output rv_pkg::pc_t        fetch_addr_o,
    output rv_pkg::fetched_t   fetched_o
);

    import rv_pkg::*;

    fetch_state_t state_q;
    pc_t          pc_q;
    logic         capture;

    // req and ack both high on this edge
    assign capture = (state_q == FETCH_WAIT_ACK) && fetch_ack_i;

    always_ff @(posedge mem2wb_inst_selfdefine_o) begin
        if (reset) begin
            state_q <= FETCH_REQ;
            pc_q    <= `RV_PC_RESET;
        end else begin
            case (state_q)
                FETCH_REQ: begin
                    state_q <= FETCH_WAIT_ACK;
                end
                FETCH_WAIT_ACK: begin
                    if (fetch_ack_i) begin
                        state_q <= FETCH_WAIT_RELEASE;
                        pc_q    <= pc_q + `RV_PC_STEP;
                    end
                end
                FETCH_WAIT_RELEASE: begin
                    // next request only once ack was seen low
                    if (!fetch_ack_i) begin
                        state_q <= FETCH_WAIT_ACK;
                    end
                end
                default: begin
                    state_q <= FETCH_REQ;
                end
            endcase
        end
    end

    assign fetch_req_o  = (state_q == FETCH_WAIT_ACK);
    assign fetch_addr_o = pc_q;

    always_comb begin
        fetched_o.valid = capture;
        fetched_o.pc    = pc_q;
        fetched_o.inst  = fetch_data_i;
    end

    a_addr_stable: assert property (@(posedge mem2wb_inst_selfdefine_o) disable iff (reset)
        (fetch_req_o && $past(fetch_req_o)) |-> $stable(fetch_addr_o));

endmodule

`default_nettype wire

// ==== reg_file.sv ====
`default_nettype none

`include "rv_params.svh"

module reg_file (
    input  wire                   mem2wb_inst_selfdefine_o,
    input  wire                   reset,
    input  wire rv_pkg::reg_idx_t rs1_idx_i,
    input  wire rv_pkg::reg_idx_t rs2_idx_i,
    output rv_pkg::xlen_t         rs1_data_o,
    output rv_pkg::xlen_t         rs2_data_o,
    input  wire rv_pkg::commit_t  commit_i
);

    import rv_pkg::*;

    xlen_t regs [`RV_REG_COUNT];
    logic  wr_en;

    // x0 is never written
    assign wr_en = commit_i.valid && commit_i.rd_en && (commit_i.rd_idx != '0);

    always_ff @(posedge mem2wb_inst_selfdefine_o) begin
        if (reset) begin
            for (int i = 0; i < `RV_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[commit_i.rd_idx] <= commit_i.rd_data;
        end
    end

    // a same-cycle write wins over the array
    assign rs1_data_o = (rs1_idx_i == '0) ? '0 :
                        (wr_en && commit_i.rd_idx == rs1_idx_i) ? commit_i.rd_data :
                        regs[rs1_idx_i];
    assign rs2_data_o = (rs2_idx_i == '0) ? '0 :
                        (wr_en && commit_i.rd_idx == rs2_idx_i) ? commit_i.rd_data :
                        regs[rs2_idx_i];

endmodule

`default_nettype wire

// ==== inst_decode.sv ====
`default_nettype none

module inst_decode (
    input  wire                   mem2wb_inst_selfdefine_o,
    input  wire                   reset,
    input  wire rv_pkg::fetched_t fetched_i,
    output rv_pkg::decoded_t      decoded_o,
    input  wire rv_pkg::commit_t  commit_i
);

    import rv_pkg::*;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    fetched_t fetch_q;
    xlen_t    rs1_data;
    xlen_t    rs2_data;
    xlen_t    imm_i;
    xlen_t    imm_u;
    logic     is_op;
    logic     is_op_imm;
    logic     is_lui;
    logic     alt;
    alu_op_t  alu_op;
    reg_idx_t rs1_idx;
    reg_idx_t rs2_idx;

    always_ff @(posedge mem2wb_inst_selfdefine_o) begin
        if (reset) begin
            fetch_q.valid <= 1'b0;
        end else begin
            fetch_q.valid <= fetched_i.valid;
        end
        fetch_q.pc   <= fetched_i.pc;
        fetch_q.inst <= fetched_i.inst;
    end

    assign is_op     = (fetch_q.inst[6:0] == OPC_OP);
    assign is_op_imm = (fetch_q.inst[6:0] == OPC_OP_IMM);
    assign is_lui    = (fetch_q.inst[6:0] == OPC_LUI);
    // funct7 bit 5 selects sub and sra
    assign alt       = fetch_q.inst[30];

    assign imm_i = {{20{fetch_q.inst[31]}}, fetch_q.inst[31:20]};
    assign imm_u = {fetch_q.inst[31:12], 12'b0};

    always_comb begin
        case (fetch_q.inst[14:12])
            3'b000:  alu_op = (is_op && alt) ? ALU_SUB : ALU_ADD;
            3'b001:  alu_op = ALU_SLL;
            3'b010:  alu_op = ALU_SLT;
            3'b011:  alu_op = ALU_SLTU;
            3'b100:  alu_op = ALU_XOR;
            3'b101:  alu_op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  alu_op = ALU_OR;
            default: alu_op = ALU_AND;
        endcase
        if (is_lui) begin
            alu_op = ALU_PASS_B;
        end
    end

    // unused sources read as x0 so they never match a forward
    assign rs1_idx = (is_op || is_op_imm) ? fetch_q.inst[19:15] : '0;
    assign rs2_idx = is_op ? fetch_q.inst[24:20] : '0;

    reg_file i_reg_file (
        .mem2wb_inst_selfdefine_o (mem2wb_inst_selfdefine_o),
        .reset                    (reset),
        .rs1_idx_i                (rs1_idx),
        .rs2_idx_i                (rs2_idx),
        .rs1_data_o               (rs1_data),
        .rs2_data_o               (rs2_data),
        .commit_i                 (commit_i)
    );

    always_comb begin
        decoded_o.valid   = fetch_q.valid;
        decoded_o.pc      = fetch_q.pc;
        decoded_o.alu_op  = alu_op;
        decoded_o.rd_idx  = fetch_q.inst[11:7];
        // unknown opcodes and rd of x0 retire without a write
        decoded_o.rd_en   = (is_op || is_op_imm || is_lui) && (fetch_q.inst[11:7] != '0);
        decoded_o.rs1_idx = rs1_idx;
        decoded_o.rs2_idx = rs2_idx;
        decoded_o.use_rs2 = is_op;
        decoded_o.op_a    = rs1_data;
        decoded_o.op_b    = is_op ? rs2_data : (is_lui ? imm_u : imm_i);
    end

endmodule

`default_nettype wire

// ==== alu_execute.sv ====
`default_nettype none

module alu_execute (
    input  wire                   mem2wb_inst_selfdefine_o,
    input  wire                   reset,
    input  wire rv_pkg::decoded_t decoded_i,
    input  wire rv_pkg::commit_t  commit_fwd_i,
    output rv_pkg::commit_t       exec_o
);

    import rv_pkg::*;

    xlen_t      op_a;
    xlen_t      op_b;
    xlen_t      result;
    logic       fwd_ok;
    logic       fwd_a;
    logic       fwd_b;
    logic [4:0] shamt;

    // commit stage result overrides the register file value
    assign fwd_ok = commit_fwd_i.valid && commit_fwd_i.rd_en && (commit_fwd_i.rd_idx != '0);
    assign fwd_a  = fwd_ok && (commit_fwd_i.rd_idx == decoded_i.rs1_idx);
    assign fwd_b  = fwd_ok && decoded_i.use_rs2 && (commit_fwd_i.rd_idx == decoded_i.rs2_idx);

    assign op_a  = fwd_a ? commit_fwd_i.rd_data : decoded_i.op_a;
    assign op_b  = fwd_b ? commit_fwd_i.rd_data : decoded_i.op_b;
    assign shamt = op_b[4:0];

    always_comb begin
        result = '0;
        case (decoded_i.alu_op)
            ALU_ADD:    result = op_a + op_b;
            ALU_SUB:    result = op_a - op_b;
            ALU_AND:    result = op_a & op_b;
            ALU_OR:     result = op_a | op_b;
            ALU_XOR:    result = op_a ^ op_b;
            ALU_SLL:    result = op_a << shamt;
            ALU_SRL:    result = op_a >> shamt;
            ALU_SRA:    result = $signed(op_a) >>> shamt;
            ALU_SLT:    result[0] = $signed(op_a) < $signed(op_b);
            ALU_SLTU:   result[0] = op_a < op_b;
            ALU_PASS_B: result = op_b;
            default:    result = '0;
        endcase
    end

    always_ff @(posedge mem2wb_inst_selfdefine_o) begin
        if (reset) begin
            exec_o.valid <= 1'b0;
        end else begin
            exec_o.valid <= decoded_i.valid;
        end
        exec_o.pc      <= decoded_i.pc;
        exec_o.rd_idx  <= decoded_i.rd_idx;
        exec_o.rd_en   <= decoded_i.rd_en;
        exec_o.rd_data <= result;
    end

    a_no_x0_write: assert property (@(posedge mem2wb_inst_selfdefine_o) disable iff (reset)
        exec_o.valid |-> !(exec_o.rd_en && exec_o.rd_idx == '0));

endmodule

`default_nettype wire

// ==== result_commit.sv ====
`default_nettype none

module result_commit (
    input  wire                  mem2wb_inst_selfdefine_o,
    input  wire                  reset,
    input  wire rv_pkg::commit_t exec_i,
    output rv_pkg::commit_t      commit_o,
    output logic                 retire_valid_o,
    output rv_pkg::commit_t      retire_o
);

    import rv_pkg::*;

    commit_t commit_q;

    always_ff @(posedge mem2wb_inst_selfdefine_o) begin
        if (reset) begin
            commit_q.valid <= 1'b0;
        end else begin
            commit_q.valid <= exec_i.valid;
        end
        commit_q.pc      <= exec_i.pc;
        commit_q.rd_idx  <= exec_i.rd_idx;
        commit_q.rd_en   <= exec_i.rd_en;
        commit_q.rd_data <= exec_i.rd_data;
    end

    // same entry feeds forwarding, the write port and retire
    assign commit_o       = commit_q;
    assign retire_valid_o = commit_q.valid;
    assign retire_o       = commit_q;

endmodule

`default_nettype wire

// ==== rv_core.sv ====
`default_nettype none

module rv_core (
    input  wire                mem2wb_inst_selfdefine_o,
    input  wire                reset,
    output logic               fetch_req_o,
    output rv_pkg::pc_t        fetch_addr_o,
    input  wire                fetch_ack_i,
    input  wire rv_pkg::inst_t fetch_data_i,
    output logic               retire_valid_o,
    output rv_pkg::commit_t    retire_o
);

    import rv_pkg::*;

    fetched_t fetched;
    decoded_t decoded;
    commit_t  exec;
    commit_t  commit;

    inst_fetch i_inst_fetch (
        .mem2wb_inst_selfdefine_o (mem2wb_inst_selfdefine_o),
        .reset                    (reset),
        .fetch_ack_i              (fetch_ack_i),
        .fetch_data_i             (fetch_data_i),
        .fetch_req_o              (fetch_req_o),
        .fetch_addr_o             (fetch_addr_o),
        .fetched_o                (fetched)
    );

    inst_decode i_inst_decode (
        .mem2wb_inst_selfdefine_o (mem2wb_inst_selfdefine_o),
        .reset                    (reset),
        .fetched_i                (fetched),
        .decoded_o                (decoded),
        .commit_i                 (commit)
    );

    alu_execute i_alu_execute (
        .mem2wb_inst_selfdefine_o (mem2wb_inst_selfdefine_o),
        .reset                    (reset),
        .decoded_i                (decoded),
        .commit_fwd_i             (commit),
        .exec_o                   (exec)
    );

    result_commit i_result_commit (
        .mem2wb_inst_selfdefine_o (mem2wb_inst_selfdefine_o),
        .reset                    (reset),
        .exec_i                   (exec),
        .commit_o                 (commit),
        .retire_valid_o           (retire_valid_o),
        .retire_o                 (retire_o)
    );

endmodule

`default_nettype wire

// ==== tb_rv_core.sv ====
`default_nettype none

`include "rv_params.svh"

module tb_rv_core;

    import rv_pkg::*;

    localparam int PROG_LEN   = 40;
    localparam int TOTAL      = PROG_LEN + 4;
    localparam int MAX_FETCH  = 6;
    localparam int LIMIT      = 10 * TOTAL * MAX_FETCH;
    localparam int FWD_FIRST  = 24;
    localparam int FWD_LAST   = 28;
    localparam inst_t NOP     = 32'h0000_0013;

    logic    mem2wb_inst_selfdefine_o;
    logic    reset;
    logic    fetch_req;
    pc_t     fetch_addr;
    logic    fetch_ack;
    inst_t   fetch_data;
    logic    retire_valid;
    commit_t retire;

    inst_t prog [PROG_LEN];
    xlen_t model_regs [`RV_REG_COUNT];
    pc_t   model_pc;
    pc_t   exp_fetch_addr;
    int    wait_cnt;
    int    retired;
    int    errors;
    int    cycles;

    rv_core i_rv_core (
        .mem2wb_inst_selfdefine_o (mem2wb_inst_selfdefine_o),
        .reset                    (reset),
        .fetch_req_o              (fetch_req),
        .fetch_addr_o             (fetch_addr),
        .fetch_ack_i              (fetch_ack),
        .fetch_data_i             (fetch_data),
        .retire_valid_o           (retire_valid),
        .retire_o                 (retire)
    );

    function automatic inst_t enc_r(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1,
                                    logic [2:0] f3, reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic inst_t enc_i(logic [11:0] imm, reg_idx_t rs1, logic [2:0] f3,
                                    reg_idx_t rd);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic inst_t enc_u(logic [19:0] imm, reg_idx_t rd);
        return {imm, rd, 7'b0110111};
    endfunction

    // past the program the memory serves addi x0 only
    function automatic inst_t mem_word(pc_t addr);
        int idx;
        idx = int'(addr >> 2);
        if (idx < PROG_LEN) begin
            return prog[idx];
        end
        return NOP;
    endfunction

    // forwarding block runs with an immediate ack
    function automatic int pick_ack_delay(pc_t addr);
        int idx;
        idx = int'(addr >> 2);
        if (idx >= FWD_FIRST && idx <= FWD_LAST) begin
            return 0;
        end
        return int'($urandom % 4);
    endfunction

    function automatic xlen_t ref_alu(logic [2:0] f3, logic alt, xlen_t a, xlen_t b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return {31'b0, $signed(a) < $signed(b)};
            3'b011:  return {31'b0, a < b};
            3'b100:  return a ^ b;
            3'b101:  return alt ? xlen_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic build_program();
        logic [31:0] rnd;
        rnd = $urandom;
        prog[0] = enc_u(rnd[31:12], 5'd1);
        prog[1] = enc_i(rnd[11:0], 5'd1, 3'b000, 5'd1);
        rnd = $urandom;
        prog[2] = enc_u(rnd[31:12], 5'd2);
        prog[3] = enc_i(rnd[11:0], 5'd2, 3'b000, 5'd2);
        for (int i = 0; i < 8; i++) begin
            prog[4 + i] = enc_r(7'h00, 5'd2, 5'd1, 3'(i), 5'(3 + i));
        end
        prog[12] = enc_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd11);
        prog[13] = enc_r(7'h20, 5'd2, 5'd1, 3'b101, 5'd12);
        for (int i = 0; i < 8; i++) begin
            rnd = $urandom;
            if (i == 1 || i == 5) begin
                rnd[11:5] = 7'h00;
            end
            prog[14 + i] = enc_i(rnd[11:0], 5'd1, 3'(i), 5'(13 + i));
        end
        rnd = $urandom;
        prog[22] = enc_i({7'h20, rnd[4:0]}, 5'd2, 3'b101, 5'd21);
        prog[23] = enc_u(rnd[31:12], 5'd22);
        // dependent chain at distances 1 to 3
        prog[24] = enc_i(12'd5, 5'd1, 3'b000, 5'd23);
        prog[25] = enc_r(7'h00, 5'd2, 5'd23, 3'b000, 5'd24);
        prog[26] = enc_r(7'h20, 5'd24, 5'd23, 3'b000, 5'd25);
        prog[27] = enc_r(7'h00, 5'd25, 5'd23, 3'b100, 5'd26);
        prog[28] = enc_r(7'h00, 5'd26, 5'd24, 3'b110, 5'd27);
        // x0 targets and an undefined opcode
        prog[29] = enc_i(12'd123, 5'd1, 3'b000, 5'd0);
        prog[30] = enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd0);
        prog[31] = 32'hffff_ffff;
        prog[32] = enc_r(7'h00, 5'd1, 5'd0, 3'b000, 5'd28);
        prog[33] = enc_i(12'd7, 5'd0, 3'b000, 5'd29);
        prog[34] = enc_r(7'h20, 5'd2, 5'd0, 3'b000, 5'd30);
        prog[35] = enc_r(7'h00, 5'd0, 5'd0, 3'b110, 5'd31);
        for (int i = 36; i < PROG_LEN; i++) begin
            rnd = $urandom;
            prog[i] = enc_r({1'b0, rnd[0] && (rnd[3:1] == 3'b000 || rnd[3:1] == 3'b101),
                             5'b0}, 5'(1 + rnd[8:4] % 31), 5'(1 + rnd[13:9] % 31),
                            rnd[3:1], 5'(1 + rnd[18:14] % 31));
        end
    endtask

    task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] exp);
        errors++;
        $display("[ERROR] %s got %h expected %h at pc %h", name, got, exp, model_pc);
    endtask

    task automatic check_retire();
        inst_t inst;
        xlen_t res;
        logic  known;
        logic  exp_en;
        inst  = mem_word(model_pc);
        known = 1'b1;
        case (inst[6:0])
            7'b0110011: res = ref_alu(inst[14:12], inst[30], model_regs[inst[19:15]],
                                      model_regs[inst[24:20]]);
            7'b0010011: res = ref_alu(inst[14:12], inst[30] && inst[14:12] == 3'b101,
                                      model_regs[inst[19:15]],
                                      {{20{inst[31]}}, inst[31:20]});
            7'b0110111: res = {inst[31:12], 12'b0};
            default: begin
                res   = '0;
                known = 1'b0;
            end
        endcase
        exp_en = known && (inst[11:7] != 5'd0);
        assert (retire.valid == 1'b1)
            else report_mismatch("retire_o.valid", 32'(retire.valid), 32'h1);
        assert (retire.pc == model_pc) else report_mismatch("retire_o.pc", retire.pc, model_pc);
        assert (retire.rd_en == exp_en)
            else report_mismatch("retire_o.rd_en", 32'(retire.rd_en), 32'(exp_en));
        if (exp_en) begin
            assert (retire.rd_idx == inst[11:7])
                else report_mismatch("retire_o.rd_idx", 32'(retire.rd_idx), 32'(inst[11:7]));
            assert (retire.rd_data == res)
                else report_mismatch("retire_o.rd_data", retire.rd_data, res);
            model_regs[inst[11:7]] = res;
        end
        model_pc = model_pc + `RV_PC_STEP;
        retired++;
    endtask

    initial begin
        mem2wb_inst_selfdefine_o = 1'b0;
        forever begin
            #50 mem2wb_inst_selfdefine_o = ~mem2wb_inst_selfdefine_o;
        end
    end

    always @(posedge mem2wb_inst_selfdefine_o) begin
        cycles++;
    end

    // memory side of the four-phase fetch handshake
    always @(posedge mem2wb_inst_selfdefine_o) begin
        #10;
        if (reset) begin
            fetch_ack = 1'b0;
        end else if (fetch_ack && !fetch_req) begin
            fetch_ack = 1'b0;
            wait_cnt  = pick_ack_delay(fetch_addr);
        end else if (fetch_req && !fetch_ack) begin
            if (wait_cnt == 0) begin
                fetch_ack  = 1'b1;
                fetch_data = mem_word(fetch_addr);
            end else begin
                wait_cnt--;
            end
        end
    end

    always @(negedge mem2wb_inst_selfdefine_o) begin
        if (!reset) begin
            if (fetch_req && fetch_ack) begin
                assert (fetch_addr == exp_fetch_addr)
                    else report_mismatch("fetch_addr_o", fetch_addr, exp_fetch_addr);
                exp_fetch_addr = exp_fetch_addr + `RV_PC_STEP;
            end
            if (retire_valid) begin
                check_retire();
            end
        end
    end

    a_req_after_release: assert property (@(posedge mem2wb_inst_selfdefine_o)
        disable iff (reset) $rose(fetch_req) |-> !$past(fetch_ack))
        else begin
            errors++;
            $display("handshake error: fetch_req_o rose while fetch_ack_i was still high");
        end

    a_req_until_ack: assert property (@(posedge mem2wb_inst_selfdefine_o)
        disable iff (reset) $fell(fetch_req) |-> $past(fetch_ack))
        else begin
            errors++;
            $display("handshake error: fetch_req_o fell before fetch_ack_i was seen");
        end

    a_addr_held: assert property (@(posedge mem2wb_inst_selfdefine_o)
        disable iff (reset) (fetch_req && $past(fetch_req)) |-> $stable(fetch_addr))
        else begin
            errors++;
            $display("handshake error: fetch_addr_o changed while fetch_req_o was high");
        end

    initial begin
        void'($urandom(51));
        reset          = 1'b1;
        fetch_ack      = 1'b0;
        fetch_data     = NOP;
        errors         = 0;
        retired        = 0;
        cycles         = 0;
        model_pc       = `RV_PC_RESET;
        exp_fetch_addr = `RV_PC_RESET;
        for (int i = 0; i < `RV_REG_COUNT; i++) begin
            model_regs[i] = '0;
        end
        build_program();
        wait_cnt = pick_ack_delay(`RV_PC_RESET);
        repeat (16) @(posedge mem2wb_inst_selfdefine_o);
        #10 reset = 1'b0;
        wait (retired == TOTAL || cycles >= LIMIT);
        if (retired != TOTAL) begin
            errors++;
            $display("timeout: only %0d of %0d instructions retired", retired, TOTAL);
        end
        $display("retired %0d instructions in %0d cycles, %0d errors", retired, cycles, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+.
rv_pkg.sv
inst_fetch.sv
reg_file.sv
inst_decode.sv
alu_execute.sv
result_commit.sv
rv_core.sv
tb_rv_core.sv

// ==== run.sh ====
#!/bin/sh
# builds the rv_core testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_rv_core \
    -o sim_tb_rv_core
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_tb_rv_core > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Simulation passed$" sim.log; then
    exit 0
fi
exit 1
